//--- flist.f
source/cpu_host_pkg.sv
source/word_sram.sv
source/seg_addr_gen.sv
source/host_link_fsm.sv
source/cpu_host_top.sv
tb/tb_clk_gen.sv
tb/cpu_host_chk.sv
tb/tb_cpu_host.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cpu host link testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cpu_host -f flist.f

out=$(./obj_dir/Vtb_cpu_host)
echo "$out"
echo "$out" | grep -q "TEST RESULT: PASS"

//--- source/cpu_host_pkg.sv
//////////////////////////////
// cpu host link package
// host op codes, word types, address map and the
// data-segment table used by the boot loader
//////////////////////////////

package cpu_host_pkg;

    // command on the host link
    typedef enum logic [1:0] {
        OP_IDLE  = 2'b00,
        OP_READ  = 2'b01,
        OP_WRITE = 2'b11
    } host_op_t;

    typedef logic [31:0] data_t;      // data memory word
    typedef logic [31:0] instr_t;     // instruction word
    typedef logic [15:0] addr_t;      // core byte address
    typedef logic [63:0] host_addr_t;

    //////////////////////////////
    // address map
    //////////////////////////////

    localparam addr_t WORD_BYTES    = 16'd4;
    localparam int    SEG_WORDS     = 16;
    localparam int    DM_SEGS       = 17;
    localparam int    IM_SEGS       = 48;
    localparam addr_t IM_SEG_STRIDE = 16'd64;
    localparam int    IM_SPACE_BIT  = 48;     // marks instruction space on the host
    localparam addr_t HOST_BASE     = 16'h9000;

    localparam int DM_WORDS = int'(HOST_BASE / WORD_BYTES);
    localparam int IM_WORDS = IM_SEGS * SEG_WORDS;

    localparam int SEG_IDX_W  = 6;
    localparam int WORD_IDX_W = 4;

    // data segments are not evenly spaced, last one sits low
    localparam addr_t DM_SEG_BASE [DM_SEGS] = '{
        16'h1000, 16'h1040, 16'h1100, 16'h1140,
        16'h2000, 16'h2040, 16'h2100, 16'h2140,
        16'h3000, 16'h3040, 16'h3100, 16'h3140,
        16'h4000, 16'h4040, 16'h4100, 16'h4140,
        16'h0100
    };

endpackage

//--- source/cpu_host_top.sv
//////////////////////////////
// cpu host link top level
// boot loader, segment addressing and the on-chip
// data and instruction memories
//////////////////////////////

`timescale 1ns/1ps

module cpu_host_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  cpu_host_pkg::data_t      host_rd_data,
    input  logic                     host_rd_valid,
    input  logic                     host_tx_done,
    input  logic                     core_st_valid,
    input  cpu_host_pkg::addr_t      core_st_addr,
    input  cpu_host_pkg::data_t      core_st_data,
    input  cpu_host_pkg::addr_t      core_ld_addr,
    input  cpu_host_pkg::addr_t      fetch_addr,
    output cpu_host_pkg::host_op_t   host_op,
    output cpu_host_pkg::host_addr_t host_addr,
    output cpu_host_pkg::data_t      host_wr_data,
    output logic                     core_st_ready,
    output cpu_host_pkg::data_t      core_ld_data,
    output cpu_host_pkg::instr_t     fetch_instr,
    output logic                     boot_done
);

    cpu_host_pkg::host_addr_t host_rd_addr;
    cpu_host_pkg::addr_t      mem_wr_addr;
    cpu_host_pkg::addr_t      dm_wr_addr;
    cpu_host_pkg::data_t      dm_wr_data;
    cpu_host_pkg::instr_t     im_wr_data;
    logic                     seg_last_word;
    logic                     seg_last;
    logic                     load_im;
    logic                     beat_en;
    logic                     seg_step;
    logic                     dm_wr_en;
    logic                     im_wr_en;

    // data memory takes boot beats in the data phase, core stores after it
    assign dm_wr_addr = load_im ? core_st_addr : mem_wr_addr;
    assign dm_wr_data = load_im ? core_st_data : host_rd_data;
    assign im_wr_data = cpu_host_pkg::instr_t'(host_rd_data);

    host_link_fsm u_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .host_rd_valid (host_rd_valid),
        .host_tx_done  (host_tx_done),
        .host_rd_addr  (host_rd_addr),
        .seg_last_word (seg_last_word),
        .seg_last      (seg_last),
        .core_st_valid (core_st_valid),
        .core_st_addr  (core_st_addr),
        .core_st_data  (core_st_data),
        .host_op       (host_op),
        .host_addr     (host_addr),
        .host_wr_data  (host_wr_data),
        .load_im       (load_im),
        .beat_en       (beat_en),
        .seg_step      (seg_step),
        .dm_wr_en      (dm_wr_en),
        .im_wr_en      (im_wr_en),
        .core_st_ready (core_st_ready),
        .boot_done     (boot_done)
    );

    seg_addr_gen u_seg (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_im       (load_im),
        .beat_en       (beat_en),
        .seg_step      (seg_step),
        .host_rd_addr  (host_rd_addr),
        .mem_wr_addr   (mem_wr_addr),
        .seg_last_word (seg_last_word),
        .seg_last      (seg_last)
    );

    word_sram #(
        .payload_t (cpu_host_pkg::data_t),
        .DEPTH     (cpu_host_pkg::DM_WORDS)
    ) u_dmem (
        .clk     (clk),
        .wr_en   (dm_wr_en),
        .wr_addr (dm_wr_addr),
        .wr_data (dm_wr_data),
        .rd_addr (core_ld_addr),
        .rd_data (core_ld_data)
    );

    word_sram #(
        .payload_t (cpu_host_pkg::instr_t),
        .DEPTH     (cpu_host_pkg::IM_WORDS)
    ) u_imem (
        .clk     (clk),
        .wr_en   (im_wr_en),
        .wr_addr (mem_wr_addr),
        .wr_data (im_wr_data),
        .rd_addr (fetch_addr),
        .rd_data (fetch_instr)
    );

endmodule

//--- source/host_link_fsm.sv
//////////////////////////////
// host link controller
// sequences the boot segment reads, then routes core
// stores to data memory or out to the host
//////////////////////////////

`timescale 1ns/1ps

module host_link_fsm (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     host_rd_valid,
    input  logic                     host_tx_done,
    input  cpu_host_pkg::host_addr_t host_rd_addr,
    input  logic                     seg_last_word,
    input  logic                     seg_last,
    input  logic                     core_st_valid,
    input  cpu_host_pkg::addr_t      core_st_addr,
    input  cpu_host_pkg::data_t      core_st_data,
    output cpu_host_pkg::host_op_t   host_op,
    output cpu_host_pkg::host_addr_t host_addr,
    output cpu_host_pkg::data_t      host_wr_data,
    output logic                     load_im,
    output logic                     beat_en,
    output logic                     seg_step,
    output logic                     dm_wr_en,
    output logic                     im_wr_en,
    output logic                     core_st_ready,
    output logic                     boot_done
);

    typedef enum logic [2:0] {
        BOOT_DM,
        SEG_GAP_DM,
        BOOT_IM,
        SEG_GAP_IM,
        RUN,
        HOST_WR
    } state_t;

    state_t                 state;
    state_t                 next_state;
    cpu_host_pkg::host_op_t next_op;
    cpu_host_pkg::addr_t    host_wr_addr;
    logic                   st_low;
    logic                   st_open;
    logic                   st_local;
    logic                   st_fwd;
    logic                   last_beat;

    //////////////////////////////
    // store routing
    //////////////////////////////

    assign st_low   = core_st_addr < cpu_host_pkg::HOST_BASE;
    assign st_open  = boot_done && (state != HOST_WR);  // no store while host write pending
    assign st_local = st_open && core_st_valid && st_low;
    assign st_fwd   = st_open && core_st_valid && !st_low;

    assign load_im   = (state != BOOT_DM) && (state != SEG_GAP_DM);
    assign beat_en   = host_rd_valid && (state == BOOT_DM || state == BOOT_IM);
    assign last_beat = beat_en && seg_last_word;
    assign dm_wr_en  = (beat_en && state == BOOT_DM) || st_local;
    assign im_wr_en  = beat_en && state == BOOT_IM;

    assign core_st_ready = st_local || (state == HOST_WR && host_tx_done);

    assign host_addr = (host_op == cpu_host_pkg::OP_WRITE) ?
                       cpu_host_pkg::host_addr_t'(host_wr_addr) : host_rd_addr;

    //////////////////////////////
    // next state
    //////////////////////////////

    always_comb begin
        next_state = state;
        seg_step   = 1'b0;
        case (state)
            BOOT_DM: begin
                if (last_beat) next_state = SEG_GAP_DM;
            end
            SEG_GAP_DM: begin
                seg_step   = !seg_last;
                next_state = seg_last ? BOOT_IM : BOOT_DM;
            end
            BOOT_IM: begin
                if (last_beat) next_state = SEG_GAP_IM;
            end
            SEG_GAP_IM: begin
                seg_step = !seg_last;
                if (!seg_last) begin
                    next_state = BOOT_IM;
                end else if (st_fwd) begin
                    next_state = HOST_WR;   // boot already done here
                end else begin
                    next_state = RUN;
                end
            end
            RUN: begin
                if (st_fwd) next_state = HOST_WR;
            end
            HOST_WR: begin
                if (host_tx_done) next_state = RUN;
            end
            default: next_state = BOOT_DM;
        endcase
    end

    // host op is registered off the next state
    always_comb begin
        case (next_state)
            BOOT_DM, BOOT_IM: next_op = cpu_host_pkg::OP_READ;
            HOST_WR:          next_op = cpu_host_pkg::OP_WRITE;
            default:          next_op = cpu_host_pkg::OP_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= BOOT_DM;
            host_op   <= cpu_host_pkg::OP_IDLE;
            boot_done <= 1'b0;
        end else begin
            state   <= next_state;
            host_op <= next_op;
            if (state == BOOT_IM && last_beat && seg_last)
                boot_done <= 1'b1;  // sticky until reset
        end
    end

    // high store held on the host lines until transfer done
    always_ff @(posedge clk) begin
        if (st_fwd) begin
            host_wr_addr <= core_st_addr;
            host_wr_data <= core_st_data;
        end
    end

endmodule

//--- source/seg_addr_gen.sv
//////////////////////////////
// boot segment address generator
// segment and word counters, host read base and
// memory byte address per beat
//////////////////////////////

`timescale 1ns/1ps

module seg_addr_gen (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load_im,
    input  logic                     beat_en,
    input  logic                     seg_step,
    output cpu_host_pkg::host_addr_t host_rd_addr,
    output cpu_host_pkg::addr_t      mem_wr_addr,
    output logic                     seg_last_word,
    output logic                     seg_last
);

    typedef logic [cpu_host_pkg::SEG_IDX_W-1:0]          seg_idx_t;
    typedef logic [cpu_host_pkg::WORD_IDX_W-1:0]         word_idx_t;
    typedef logic [$clog2(cpu_host_pkg::DM_SEGS)-1:0]    dm_idx_t;

    seg_idx_t            seg_idx;
    seg_idx_t            seg_cur;
    word_idx_t           word_idx;
    logic                load_im_q;
    logic                phase_start;
    cpu_host_pkg::addr_t seg_base;

    // index reads as zero in the first cycle of the instruction phase
    assign phase_start = load_im && !load_im_q;
    assign seg_cur     = phase_start ? '0 : seg_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seg_idx   <= '0;
            word_idx  <= '0;
            load_im_q <= 1'b0;
        end else begin
            load_im_q <= load_im;
            if (beat_en) word_idx <= word_idx + 1'b1;   // wraps after 16 beats
            if (seg_step) begin
                seg_idx <= seg_cur + 1'b1;
            end else if (phase_start) begin
                seg_idx <= '0;
            end
        end
    end

    assign seg_base = load_im ?
                      cpu_host_pkg::addr_t'(seg_cur) * cpu_host_pkg::IM_SEG_STRIDE :
                      cpu_host_pkg::DM_SEG_BASE[dm_idx_t'(seg_cur)];

    assign mem_wr_addr  = seg_base + cpu_host_pkg::addr_t'(word_idx) * cpu_host_pkg::WORD_BYTES;
    assign host_rd_addr = cpu_host_pkg::host_addr_t'(seg_base) |
                          (cpu_host_pkg::host_addr_t'(load_im) << cpu_host_pkg::IM_SPACE_BIT);

    assign seg_last_word = word_idx == word_idx_t'(cpu_host_pkg::SEG_WORDS - 1);
    assign seg_last      = seg_cur == (load_im ? seg_idx_t'(cpu_host_pkg::IM_SEGS - 1) :
                                                 seg_idx_t'(cpu_host_pkg::DM_SEGS - 1));

endmodule

//--- source/word_sram.sv
//////////////////////////////
// word memory
// one write port, one registered read port,
// byte addressed, one word per entry
//////////////////////////////

`timescale 1ns/1ps

module word_sram #(
    parameter type payload_t = cpu_host_pkg::data_t,
    parameter int  DEPTH     = 1024
) (
    input  logic                clk,
    input  logic                wr_en,
    input  cpu_host_pkg::addr_t wr_addr,
    input  payload_t            wr_data,
    input  cpu_host_pkg::addr_t rd_addr,
    output payload_t            rd_data
);

    typedef logic [$clog2(DEPTH)-1:0] idx_t;

    payload_t mem [DEPTH];

    // read returns the old word on a same-edge write
    always_ff @(posedge clk) begin
        if (wr_en) mem[idx_t'(wr_addr >> 2)] <= wr_data;
        rd_data <= mem[idx_t'(rd_addr >> 2)];
    end

endmodule

//--- tb/cpu_host_chk.sv
//////////////////////////////
// host link protocol checks
// bound into the cpu host link top level
//////////////////////////////

`timescale 1ns/1ps

module cpu_host_chk (
    input logic                     clk,
    input logic                     rst_n,
    input cpu_host_pkg::host_op_t   host_op,
    input cpu_host_pkg::host_addr_t host_addr,
    input cpu_host_pkg::data_t      host_wr_data,
    input logic                     host_rd_valid,
    input logic                     host_tx_done,
    input logic                     core_st_ready,
    input logic                     boot_done
);

    // no host write while still booting
    a_no_write_in_boot: assert property (@(posedge clk) disable iff (!rst_n)
        !boot_done |-> host_op != cpu_host_pkg::OP_WRITE)
        else $error("host write issued before boot finished");

    a_no_ready_in_boot: assert property (@(posedge clk) disable iff (!rst_n)
        !boot_done |-> !core_st_ready)
        else $error("store ready raised before boot finished");

    // a segment read only ends on a beat
    a_read_op_held: assert property (@(posedge clk) disable iff (!rst_n)
        (host_op == cpu_host_pkg::OP_READ && !host_rd_valid) |=>
        host_op == cpu_host_pkg::OP_READ)
        else $error("read request dropped without a beat");

    a_read_addr_held: assert property (@(posedge clk) disable iff (!rst_n)
        (host_op == cpu_host_pkg::OP_READ && $past(host_op) == cpu_host_pkg::OP_READ) |->
        $stable(host_addr))
        else $error("read address changed inside a segment");

    a_write_held: assert property (@(posedge clk) disable iff (!rst_n)
        (host_op == cpu_host_pkg::OP_WRITE && !host_tx_done) |=>
        (host_op == cpu_host_pkg::OP_WRITE && $stable(host_addr) && $stable(host_wr_data)))
        else $error("host write changed before transfer done");

endmodule

bind cpu_host_top cpu_host_chk i_chk (
    .clk           (clk),
    .rst_n         (rst_n),
    .host_op       (host_op),
    .host_addr     (host_addr),
    .host_wr_data  (host_wr_data),
    .host_rd_valid (host_rd_valid),
    .host_tx_done  (host_tx_done),
    .core_st_ready (core_st_ready),
    .boot_done     (boot_done)
);

//--- tb/tb_clk_gen.sv
//////////////////////////////
// testbench clock and reset
// 4 ns clock, reset low for 4 cycles
//////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk) rst_n = 1'b1;   // released between edges
    end

endmodule

//--- tb/tb_cpu_host.sv
//////////////////////////////
// cpu host link testbench
// host model, reference memories, boot, load,
// fetch, local store and host write tests
//////////////////////////////

`timescale 1ns/1ps

module tb_cpu_host;

    localparam int BOOT_CYCLES = 65 * 16 * 4;
    localparam int RUN_CYCLES  = 2000;
    localparam int N_STORES    = 96;
    localparam int N_HOST_WR   = 8;

    logic                     clk;
    logic                     rst_n;
    cpu_host_pkg::data_t      host_rd_data;
    logic                     host_rd_valid;
    logic                     host_tx_done;
    logic                     core_st_valid;
    cpu_host_pkg::addr_t      core_st_addr;
    cpu_host_pkg::data_t      core_st_data;
    cpu_host_pkg::addr_t      core_ld_addr;
    cpu_host_pkg::addr_t      fetch_addr;
    cpu_host_pkg::host_op_t   host_op;
    cpu_host_pkg::host_addr_t host_addr;
    cpu_host_pkg::data_t      host_wr_data;
    logic                     core_st_ready;
    cpu_host_pkg::data_t      core_ld_data;
    cpu_host_pkg::instr_t     fetch_instr;
    logic                     boot_done;

    cpu_host_pkg::data_t      salt;
    cpu_host_pkg::data_t      exp_dm [int];              // keyed by byte address
    cpu_host_pkg::instr_t     exp_im [cpu_host_pkg::IM_WORDS];
    cpu_host_pkg::host_addr_t rd_log [$];
    cpu_host_pkg::addr_t      wr_log_addr [$];
    cpu_host_pkg::data_t      wr_log_data [$];
    int                       beat_count;
    time                      last_beat_time;
    int                       pass_count;
    int                       fail_count;

    tb_clk_gen u_clk (.clk(clk), .rst_n(rst_n));

    cpu_host_top i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .host_rd_data  (host_rd_data),
        .host_rd_valid (host_rd_valid),
        .host_tx_done  (host_tx_done),
        .core_st_valid (core_st_valid),
        .core_st_addr  (core_st_addr),
        .core_st_data  (core_st_data),
        .core_ld_addr  (core_ld_addr),
        .fetch_addr    (fetch_addr),
        .host_op       (host_op),
        .host_addr     (host_addr),
        .host_wr_data  (host_wr_data),
        .core_st_ready (core_st_ready),
        .core_ld_data  (core_ld_data),
        .fetch_instr   (fetch_instr),
        .boot_done     (boot_done)
    );

    // word the host returns for beat i of the segment at ha
    function automatic cpu_host_pkg::data_t host_word(cpu_host_pkg::host_addr_t ha, int i);
        cpu_host_pkg::data_t w;
        w = (ha[31:0] + 32'(i * 4)) * 32'h9e37_79b1;
        if (ha[48]) w = w ^ 32'h5a5a_0000;
        return w ^ salt;
    endfunction

    function automatic cpu_host_pkg::host_addr_t im_base(int k);
        return (64'(k) * 64) | (64'd1 << 48);
    endfunction

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_data(string what, cpu_host_pkg::data_t got, cpu_host_pkg::data_t exp);
        if (got === exp) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_instr(string what, cpu_host_pkg::instr_t got,
                               cpu_host_pkg::instr_t exp);
        if (got === exp) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_host_write(cpu_host_pkg::addr_t got_a, cpu_host_pkg::data_t got_d,
                                    cpu_host_pkg::addr_t exp_a, cpu_host_pkg::data_t exp_d);
        if (got_a === exp_a && got_d === exp_d) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("[FAIL] %0t ns: host write %h/%h expected %h/%h",
                     $time, got_a, got_d, exp_a, exp_d);
        end
    endtask

    task automatic protocol_error(string msg);
        fail_count++;
        $display("%0t ns: protocol error, %s", $time, msg);
    endtask

    task automatic report_test(string name, int fails_before);
        $display("test %s: %s", name, (fail_count == fails_before) ? "ok" : "errors");
    endtask

    //////////////////////////////
    // host model
    //////////////////////////////

    initial begin
        int gap;
        cpu_host_pkg::host_addr_t ha;
        host_rd_valid = 1'b0;
        host_rd_data  = '0;
        host_tx_done  = 1'b0;
        beat_count    = 0;
        forever begin
            @(negedge clk);
            if (rst_n && host_op == cpu_host_pkg::OP_READ) begin
                ha = host_addr;
                rd_log.push_back(ha);
                for (int i = 0; i < cpu_host_pkg::SEG_WORDS; i++) begin
                    gap = $urandom % 4;
                    repeat (gap) @(negedge clk);
                    host_rd_valid  = 1'b1;
                    host_rd_data   = host_word(ha, i);
                    beat_count++;
                    last_beat_time = $time;
                    @(negedge clk);
                    host_rd_valid = 1'b0;
                end
            end else if (rst_n && host_op == cpu_host_pkg::OP_WRITE) begin
                if (host_addr[63:16] != '0)
                    protocol_error($sformatf("host write address %h not zero-extended",
                                             host_addr));
                wr_log_addr.push_back(cpu_host_pkg::addr_t'(host_addr));
                wr_log_data.push_back(host_wr_data);
                repeat (1 + $urandom % 5) @(negedge clk);
                host_tx_done = 1'b1;
                @(negedge clk);
                host_tx_done = 1'b0;
            end
        end
    end

    // watchdog sized from boot plus run test length
    initial begin
        repeat (BOOT_CYCLES + RUN_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", BOOT_CYCLES + RUN_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic load_word(cpu_host_pkg::addr_t a, output cpu_host_pkg::data_t d);
        core_ld_addr = a;
        @(negedge clk);
        d = core_ld_data;
    endtask

    task automatic local_store(cpu_host_pkg::addr_t a, cpu_host_pkg::data_t d);
        core_st_valid = 1'b1;
        core_st_addr  = a;
        core_st_data  = d;
        #1;
        if (!core_st_ready) protocol_error($sformatf("local store to %h not accepted", a));
        exp_dm[int'(a)] = d;
        @(negedge clk);
        core_st_valid = 1'b0;
    endtask

    task automatic host_store(cpu_host_pkg::addr_t a, cpu_host_pkg::data_t d);
        int  waited;
        bit  done;
        waited = 0;
        done   = 0;
        core_st_valid = 1'b1;
        core_st_addr  = a;
        core_st_data  = d;
        while (!done) begin
            #1;
            if (core_st_ready) begin
                if (!host_tx_done) protocol_error("store ready before host transfer done");
                done = 1;
            end else if (waited == 40) begin
                protocol_error($sformatf("host store to %h never completed", a));
                done = 1;
            end
            @(negedge clk);
            waited++;
        end
        core_st_valid = 1'b0;
        if (wr_log_addr.size() != 1) begin
            protocol_error($sformatf("%0d host writes for one store", wr_log_addr.size()));
        end else begin
            check_host_write(wr_log_addr.pop_front(), wr_log_data.pop_front(), a, d);
        end
        wr_log_addr.delete();
        wr_log_data.delete();
    endtask

    initial begin
        int                   fb;
        int                   k;
        cpu_host_pkg::addr_t  a;
        cpu_host_pkg::data_t  d;
        cpu_host_pkg::addr_t  st_q [$];
        void'($urandom(32'hf726));
        salt          = $urandom;
        pass_count    = 0;
        fail_count    = 0;
        core_st_valid = 1'b0;
        core_st_addr  = '0;
        core_st_data  = '0;
        core_ld_addr  = '0;
        fetch_addr    = '0;

        // reference memories from the host word rule
        for (int s = 0; s < cpu_host_pkg::DM_SEGS; s++)
            for (int i = 0; i < cpu_host_pkg::SEG_WORDS; i++)
                exp_dm[int'(cpu_host_pkg::DM_SEG_BASE[s]) + 4 * i] =
                    host_word(64'(cpu_host_pkg::DM_SEG_BASE[s]), i);
        for (int s = 0; s < cpu_host_pkg::IM_SEGS; s++)
            for (int i = 0; i < cpu_host_pkg::SEG_WORDS; i++)
                exp_im[s * 16 + i] = host_word(im_base(s), i);

        // reset state
        fb = fail_count;
        @(posedge rst_n);
        #1;
        if (host_op != cpu_host_pkg::OP_IDLE) protocol_error("host op not idle after reset");
        if (boot_done || core_st_ready) protocol_error("boot done or ready high after reset");
        @(negedge clk);
        #1;
        if (host_op != cpu_host_pkg::OP_READ) protocol_error("no read one cycle after reset");
        report_test("reset_state", fb);

        // boot request sequence, a host store waits through it
        fb = fail_count;
        @(negedge clk);
        a = cpu_host_pkg::HOST_BASE + cpu_host_pkg::addr_t'(($urandom % 16'h1c00) * 4);
        d = $urandom;
        core_st_valid = 1'b1;
        core_st_addr  = a;
        core_st_data  = d;
        while (!boot_done) begin
            if (core_st_ready) protocol_error("store ready while still booting");
            if (host_op == cpu_host_pkg::OP_WRITE) protocol_error("host write while booting");
            @(negedge clk);
        end
        if (beat_count != 65 * 16) protocol_error("boot done before the last beat");
        if ($time - last_beat_time != 4) protocol_error("boot done not one cycle after last beat");
        if (rd_log.size() != 65) begin
            protocol_error($sformatf("%0d read requests instead of 65", rd_log.size()));
        end else begin
            for (int s = 0; s < 65; s++) begin
                if (rd_log[s] !== ((s < 17) ? 64'(cpu_host_pkg::DM_SEG_BASE[s]) :
                                              im_base(s - 17)))
                    protocol_error($sformatf("read request %0d at %h", s, rd_log[s]));
            end
        end
        host_store(a, d);   // pending store leaves right after boot
        report_test("boot_sequence", fb);

        fb = fail_count;
        for (k = 0; k < cpu_host_pkg::IM_WORDS; k++) begin
            fetch_addr = cpu_host_pkg::addr_t'(k * 4);
            @(negedge clk);
            check_instr($sformatf("fetch %0d", k), fetch_instr, exp_im[k]);
        end
        report_test("instr_contents", fb);

        fb = fail_count;
        for (int s = 0; s < cpu_host_pkg::DM_SEGS; s++)
            for (int i = 0; i < cpu_host_pkg::SEG_WORDS; i++) begin
                a = cpu_host_pkg::DM_SEG_BASE[s] + cpu_host_pkg::addr_t'(4 * i);
                load_word(a, d);
                check_data($sformatf("load %h", a), d, exp_dm[int'(a)]);
            end
        report_test("data_contents", fb);

        // local stores, some land on the same word twice
        fb = fail_count;
        for (int n = 0; n < N_STORES; n++) begin
            a = cpu_host_pkg::addr_t'(($urandom % 64) * 4) + ((n % 2) ? 16'h1000 : 16'h8000);
            local_store(a, $urandom);
            st_q.push_back(a);
        end
        foreach (st_q[j]) begin
            load_word(st_q[j], d);
            check_data($sformatf("load %h", st_q[j]), d, exp_dm[int'(st_q[j])]);
        end
        report_test("local_stores", fb);

        fb = fail_count;
        for (int n = 0; n < N_HOST_WR; n++) begin
            a = cpu_host_pkg::HOST_BASE + cpu_host_pkg::addr_t'(($urandom % 16'h1c00) * 4);
            host_store(a, $urandom);
            a = cpu_host_pkg::addr_t'(($urandom % 256) * 4);
            local_store(a, $urandom);
            load_word(a, d);
            check_data($sformatf("load %h", a), d, exp_dm[int'(a)]);
        end
        report_test("host_writes", fb);

        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
